// ==== sdram_ctrl.f ====
+incdir+include
src/sdram_pkg.sv
src/refresh_timer.sv
src/cmd_scheduler.sv
src/data_path.sv
src/sdram_ctrl.sv
test/tb_clock.sv
test/tb_sdram_ctrl.sv

// ==== Makefile ====
TOP = tb_sdram_ctrl

sim:
	verilator --binary --timing --top-module $(TOP) -f sdram_ctrl.f -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== test/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram_ctrl;

  import sdram_pkg::*;

  localparam int N_REQ       = 150;                    // per port
  localparam int TIMEOUT_CYC = 2 * N_REQ * 40 * 12 / 10;
  localparam int RESP_DLY    = `SD_CAS_LAT + 1;         // seen READ to seen rd_resp
  localparam sdram_cmd_t IDLE_CMD = '{cmd: NOOP, bank: '0, addr: '0};

  logic                  CLK;
  logic                  RST;
  host_req_t             req_drv [2] = '{'0, '0};      // 0 rand, 1 bulk
  host_req_t             req_dec [2] = '{'0, '0};      // what the DUT decided on
  logic [`SD_DATA_W-1:0] dq_in = '0;
  logic                  rand_grant;
  logic                  bulk_grant;
  sdram_cmd_t            sd_cmd;
  logic [`SD_DATA_W-1:0] dq_out;
  logic                  dq_oe;
  rd_resp_t              rd_resp;

  logic [31:0]           seed = 32'hc75f_73b5;
  int                    cyc = 0;
  logic                  rst_d = 1'b0;
  logic                  page_open = 1'b0;
  logic [`SD_ROW_W-1:0]  page_row = '0;
  logic [`SD_BANK_W-1:0] page_bank = '0;
  sdram_cmd_e            last_cmd = NOOP;
  int                    last_cyc = -100;
  int                    ref_cnt = 0;
  logic                  ref_pending = 1'b0;
  logic                  ref_closing = 1'b0;
  logic                  wr_pend = 1'b0;
  logic [`SD_ADDR_W-1:0] wr_key = '0;
  logic [`SD_DATA_W-1:0] sdram_mem [logic [`SD_ADDR_W-1:0]];   // sparse SDRAM array
  logic [`SD_DATA_W-1:0] shadow [logic [`SD_ADDR_W-1:0]];      // host view of writes
  logic [`SD_DATA_W-1:0] rd_stage [`SD_CAS_LAT-1] = '{default: '0};
  rd_resp_t              exp_q [$];
  int                    exp_cyc [$];
  int                    idle [2] = '{0, 0};
  int                    issued [2] = '{0, 0};
  int                    done [2] = '{0, 0};
  logic                  busy [2] = '{1'b0, 1'b0};

  tb_clock i_clock (.CLK(CLK), .RST(RST));

  sdram_ctrl i_dut (
    .CLK        (CLK),
    .RST        (RST),
    .rand_req   (req_drv[0]),
    .bulk_req   (req_drv[1]),
    .dq_in      (dq_in),
    .rand_grant (rand_grant),
    .bulk_grant (bulk_grant),
    .sd_cmd     (sd_cmd),
    .dq_out     (dq_out),
    .dq_oe      (dq_oe),
    .rd_resp    (rd_resp)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // 3 rows x 4 banks so both hits and misses occur
  // few columns so reads often return written data
  function automatic host_req_t new_req();
    host_req_t   r;
    logic [31:0] a;
    a = lcg_next();
    r.req   = 1'b1;
    r.we    = a[31];
    r.addr  = {4'h0, a[30:23] % 8'd3, a[22:21], 7'h0, a[13:11]};
    r.wdata = lcg_next();
    return r;
  endfunction

  function automatic logic page_hit(input host_req_t r);
    return r.req && page_open && (r.addr[`SD_ADDR_W-1 -: `SD_ROW_W] == page_row) &&
           (r.addr[`SD_COL_W +: `SD_BANK_W] == page_bank);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_cmd(input string name, input sdram_cmd_t want, input sdram_cmd_t got);
    if (got !== want)
      abort_run($sformatf("ERR %s: expected %s bank %0d addr %h actual %s bank %0d addr %h",
                          name, want.cmd.name(), want.bank, want.addr,
                          got.cmd.name(), got.bank, got.addr));
  endtask

  task automatic check_resp(input string name, input rd_resp_t want, input rd_resp_t got);
    if (got !== want)
      abort_run($sformatf("ERR %s: expected v%0b bulk%0b %h actual v%0b bulk%0b %h", name,
                          want.valid, want.bulk, want.data, got.valid, got.bulk, got.data));
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    if (got !== want)
      abort_run($sformatf("ERR %s: expected %0b actual %0b", name, want, got));
  endtask

  task automatic check_reset_state();
    check_cmd("reset sd_cmd", IDLE_CMD, sd_cmd);
    check_bit("reset rand_grant", 1'b0, rand_grant);
    check_bit("reset bulk_grant", 1'b0, bulk_grant);
    check_bit("reset dq_oe", 1'b0, dq_oe);
    check_bit("reset rd_resp.valid", 1'b0, rd_resp.valid);
  endtask

  task automatic observe_rw();
    sdram_cmd_t            want;
    host_req_t             srv;
    logic                  to_bulk;
    logic [`SD_ADDR_W-1:0] key;
    rd_resp_t              resp;
    to_bulk = page_hit(req_dec[1]);   // bulk wins a shared hit
    srv     = to_bulk ? req_dec[1] : req_dec[0];
    check_bit("grant while refresh closes page", 1'b0, ref_closing);
    check_bit("served port hits open page", 1'b1, page_hit(srv));
    check_bit("bulk grant", to_bulk, bulk_grant);
    check_bit("rand grant", !to_bulk, rand_grant);
    want               = IDLE_CMD;
    want.cmd           = srv.we ? WRTE : READ;
    want.bank          = srv.addr[`SD_COL_W +: `SD_BANK_W];
    want.addr.col.addr = srv.addr[`SD_COL_W-1:0];
    check_cmd("read/write command", want, sd_cmd);
    key = {page_row, sd_cmd.bank, sd_cmd.addr.col.addr};   // location on the SDRAM side
    if (srv.we)
    begin
      wr_pend           = 1'b1;
      wr_key            = key;
      shadow[srv.addr]  = srv.wdata;
    end
    else
    begin
      rd_stage[0] = sdram_mem.exists(key) ? sdram_mem[key] : '0;
      resp.valid  = 1'b1;
      resp.bulk   = to_bulk;
      resp.data   = shadow.exists(srv.addr) ? shadow[srv.addr] : '0;
      exp_q.push_back(resp);
      exp_cyc.push_back(cyc + RESP_DLY);
    end
  endtask

  task automatic observe_bus();
    int need;
    check_bit("dq_oe one cycle after WRTE", wr_pend, dq_oe);
    if (dq_oe)
      sdram_mem[wr_key] = dq_out;
    wr_pend = 1'b0;
    if (exp_cyc.size() > 0 && exp_cyc[0] == cyc)
    begin
      check_resp("read response", exp_q[0], rd_resp);
      void'(exp_q.pop_front());
      void'(exp_cyc.pop_front());
    end
    else
      check_bit("unexpected rd_resp.valid", 1'b0, rd_resp.valid);
    if (sd_cmd.cmd != NOOP)
    begin
      need = `SD_T_GAP;
      if (last_cmd == ARSR)
        need = `SD_T_RFC;
      else if (last_cmd == WRTE && sd_cmd.cmd == PRCH)
        need = `SD_T_WR;
      check_bit("command spacing", 1'b1, (cyc - last_cyc) >= need);
      last_cmd = sd_cmd.cmd;
      last_cyc = cyc;
    end
    if (sd_cmd.cmd != READ && sd_cmd.cmd != WRTE)
    begin
      check_bit("rand grant without read/write", 1'b0, rand_grant);
      check_bit("bulk grant without read/write", 1'b0, bulk_grant);
    end
    case (sd_cmd.cmd)
      ACTV:
      begin
        check_bit("ACTV with page open", 1'b0, page_open);
        page_open = 1'b1;
        page_row  = sd_cmd.addr.row.addr;
        page_bank = sd_cmd.bank;
      end
      PRCH:
      begin
        page_open   = 1'b0;
        ref_closing = ref_pending;   // closing for a due refresh
      end
      ARSR:
      begin
        check_bit("ARSR with page open", 1'b0, page_open);
        check_bit("ARSR with refresh due", 1'b1, ref_pending);
        ref_pending = 1'b0;
        ref_closing = 1'b0;
      end
      READ, WRTE: observe_rw();
      default: ;
    endcase
  endtask

  // mirrors the period of the refresh strobe
  task automatic count_refresh();
    if (!RST)
      ref_cnt = 0;
    else if (ref_cnt == `SD_REF_PERIOD - 1)
    begin
      check_bit("refresh served within its period", 1'b0, ref_pending);
      ref_pending = 1'b1;
      ref_cnt     = 0;
    end
    else
      ref_cnt = ref_cnt + 1;
  endtask

  always @(posedge CLK)
  begin
    cyc = cyc + 1;
    rst_d <= RST;
    if (cyc > TIMEOUT_CYC)
      abort_run($sformatf("timeout after %0d cycles with %0d rand and %0d bulk grants",
                          cyc, done[0], done[1]));
    else
    begin
      dq_in <= rd_stage[`SD_CAS_LAT-2];   // SDRAM answers the READ
      for (int i = `SD_CAS_LAT - 2; i > 0; i--)
        rd_stage[i] = rd_stage[i-1];
      rd_stage[0] = '0;
      if (!rst_d)
      begin
        if (cyc > 1)
          check_reset_state();
      end
      else
        observe_bus();
      count_refresh();
      if (RST)
      begin
        for (int p = 0; p < 2; p++)
        begin
          logic g;
          g = (p == 1) ? bulk_grant : rand_grant;
          if (g)
          begin
            done[p]    = done[p] + 1;
            busy[p]    = 1'b0;
            idle[p]    = int'(lcg_next() >> 30);   // 0 to 3 idle cycles
            req_drv[p] <= '0;
          end
          if (!busy[p] && issued[p] < N_REQ)
          begin
            if (idle[p] == 0)
            begin
              req_drv[p] <= new_req();
              busy[p]    = 1'b1;
              issued[p]  = issued[p] + 1;
            end
            else
              idle[p] = idle[p] - 1;
          end
        end
      end
      req_dec <= req_drv;
      if (done[0] == N_REQ && done[1] == N_REQ && exp_q.size() == 0)
      begin
        $display("sim passed");
        $finish;
      end
    end
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic RST
);

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;   // 4 ns period
  end

  initial
  begin
    RST <= 1'b0;
    repeat (5) @(posedge CLK);
    RST <= 1'b1;
  end

endmodule

// ==== src/sdram_ctrl.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_ctrl (
  input  logic                   CLK,
  input  logic                   RST,
  input  sdram_pkg::host_req_t   rand_req,
  input  sdram_pkg::host_req_t   bulk_req,
  input  logic [`SD_DATA_W-1:0]  dq_in,
  output logic                   rand_grant,
  output logic                   bulk_grant,
  output sdram_pkg::sdram_cmd_t  sd_cmd,
  output logic [`SD_DATA_W-1:0]  dq_out,
  output logic                   dq_oe,
  output sdram_pkg::rd_resp_t    rd_resp
);

  logic ref_strobe;   // toggles once per refresh period

  refresh_timer i_refresh_timer (
    .CLK        (CLK),
    .RST        (RST),
    .ref_strobe (ref_strobe)
  );

  cmd_scheduler i_cmd_scheduler (
    .CLK        (CLK),
    .RST        (RST),
    .ref_strobe (ref_strobe),
    .rand_req   (rand_req),
    .bulk_req   (bulk_req),
    .sd_cmd     (sd_cmd),
    .rand_grant (rand_grant),
    .bulk_grant (bulk_grant)
  );

  data_path i_data_path (
    .CLK        (CLK),
    .RST        (RST),
    .sd_cmd     (sd_cmd),
    .rand_grant (rand_grant),
    .bulk_grant (bulk_grant),
    .rand_wdata (rand_req.wdata),
    .bulk_wdata (bulk_req.wdata),
    .dq_in      (dq_in),
    .dq_out     (dq_out),
    .dq_oe      (dq_oe),
    .rd_resp    (rd_resp)
  );

endmodule

// ==== src/data_path.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module data_path (
  input  logic                   CLK,
  input  logic                   RST,
  input  sdram_pkg::sdram_cmd_t  sd_cmd,
  input  logic                   rand_grant,
  input  logic                   bulk_grant,
  input  logic [`SD_DATA_W-1:0]  rand_wdata,
  input  logic [`SD_DATA_W-1:0]  bulk_wdata,
  input  logic [`SD_DATA_W-1:0]  dq_in,
  output logic [`SD_DATA_W-1:0]  dq_out,
  output logic                   dq_oe,
  output sdram_pkg::rd_resp_t    rd_resp
);

  import sdram_pkg::*;

  logic [`SD_CAS_LAT-1:0] rd_vld;    // reads in flight
  logic [`SD_CAS_LAT-1:0] rd_own;    // set when bulk owns the stage
  logic                   resp_valid;
  logic                   resp_bulk;
  logic [`SD_DATA_W-1:0]  resp_data;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      dq_oe      <= 1'b0;
      rd_vld     <= '0;
      resp_valid <= 1'b0;
    end
    else
    begin
      dq_oe     <= (sd_cmd.cmd == WRTE);   // one cycle after the command
      rd_vld[0] <= (sd_cmd.cmd == READ);
      for (int i = 1; i < `SD_CAS_LAT; i++)
        rd_vld[i] <= rd_vld[i-1];
      resp_valid <= rd_vld[`SD_CAS_LAT-1];
    end
  end

  always_ff @(posedge CLK)
  begin
    if (sd_cmd.cmd == WRTE)
      dq_out <= rand_grant ? rand_wdata : bulk_wdata;   // grant marks the owner
    rd_own[0] <= bulk_grant;
    for (int i = 1; i < `SD_CAS_LAT; i++)
      rd_own[i] <= rd_own[i-1];
    if (rd_vld[`SD_CAS_LAT-1])
    begin
      resp_bulk <= rd_own[`SD_CAS_LAT-1];
      resp_data <= dq_in;                // cas latency reached
    end
  end

  assign rd_resp = '{valid: resp_valid, bulk: resp_bulk, data: resp_data};

endmodule

// ==== src/cmd_scheduler.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module cmd_scheduler (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  ref_strobe,
  input  sdram_pkg::host_req_t  rand_req,
  input  sdram_pkg::host_req_t  bulk_req,
  output sdram_pkg::sdram_cmd_t sd_cmd,
  output logic                  rand_grant,
  output logic                  bulk_grant
);

  import sdram_pkg::*;

  localparam int CNT_W = $clog2(`SD_T_RFC);

  localparam sdram_cmd_t CMD_IDLE = '{cmd: NOOP, bank: '0, addr: '0};

  function automatic logic [`SD_ROW_W-1:0] req_row(input host_req_t r);
    return r.addr[`SD_ADDR_W-1 -: `SD_ROW_W];
  endfunction

  function automatic logic [`SD_BANK_W-1:0] req_bank(input host_req_t r);
    return r.addr[`SD_COL_W +: `SD_BANK_W];
  endfunction

  function automatic logic [`SD_COL_W-1:0] req_col(input host_req_t r);
    return r.addr[`SD_COL_W-1:0];
  endfunction

  // open page
  logic [`SD_ROW_W-1:0]  page_row;
  logic [`SD_BANK_W-1:0] page_bank;
  logic                  page_open;

  logic                  ref_ack;
  logic                  ref_due;
  sdram_cmd_e            last_cmd;
  logic [CNT_W-1:0]      gap_cnt;
  logic [CNT_W-1:0]      gap_load;

  logic                  any_req;
  logic                  bulk_hit;
  logic                  rand_hit;
  host_req_t             sel_req;
  sdram_cmd_t            nxt;
  logic                  nxt_bulk;
  logic                  nxt_rand;
  logic                  early_ok;
  logic                  issue;

  assign ref_due = ref_strobe ^ ref_ack;           // strobe toggled since last ARSR
  assign any_req = bulk_req.req | rand_req.req;
  assign sel_req = bulk_req.req ? bulk_req : rand_req;   // bulk wins

  assign bulk_hit = bulk_req.req && page_open && !ref_due &&
                    (req_row(bulk_req) == page_row) &&
                    (req_bank(bulk_req) == page_bank);

  // rand only hits while bulk is quiet
  assign rand_hit = rand_req.req && !bulk_req.req && page_open && !ref_due &&
                    (req_row(rand_req) == page_row) &&
                    (req_bank(rand_req) == page_bank);

  always_comb
  begin
    nxt      = CMD_IDLE;
    nxt_bulk = 1'b0;
    nxt_rand = 1'b0;
    if (ref_due && page_open)
    begin
      nxt.cmd  = PRCH;       // close before refresh
      nxt.bank = page_bank;
    end
    else if (ref_due)
    begin
      nxt.cmd = ARSR;
    end
    else if (bulk_hit || rand_hit)
    begin
      nxt.cmd           = sel_req.we ? WRTE : READ;
      nxt.bank          = page_bank;
      nxt.addr.col.addr = req_col(sel_req);   // ap stays 0
      nxt_bulk          = bulk_hit;
      nxt_rand          = rand_hit;
    end
    else if (any_req && page_open)
    begin
      nxt.cmd  = PRCH;       // page miss
      nxt.bank = page_bank;
    end
    else if (any_req)
    begin
      nxt.cmd           = ACTV;
      nxt.bank          = req_bank(sel_req);
      nxt.addr.row.addr = req_row(sel_req);
    end
  end

  // gap the successor must wait after this issue
  always_comb
  begin
    case (nxt.cmd)
      ARSR:    gap_load = CNT_W'(`SD_T_RFC - 1);
      WRTE:    gap_load = CNT_W'(`SD_T_WR - 1);   // long enough for a PRCH next
      default: gap_load = CNT_W'(`SD_T_GAP - 1);
    endcase
  end

  // after a write only PRCH needs the long gap
  assign early_ok = (last_cmd == WRTE) && (nxt.cmd != PRCH) &&
                    (gap_cnt <= CNT_W'(`SD_T_WR - `SD_T_GAP));

  assign issue = (nxt.cmd != NOOP) && ((gap_cnt == '0) || early_ok);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      sd_cmd     <= CMD_IDLE;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
      page_open  <= 1'b0;
      ref_ack    <= 1'b0;
      last_cmd   <= NOOP;
      gap_cnt    <= '0;
    end
    else
    begin
      rand_grant <= issue && nxt_rand;   // lines up with READ/WRTE on the bus
      bulk_grant <= issue && nxt_bulk;
      if (issue)
      begin
        sd_cmd   <= nxt;
        last_cmd <= nxt.cmd;
        gap_cnt  <= gap_load;
      end
      else
      begin
        sd_cmd <= CMD_IDLE;
        if (gap_cnt != '0)
          gap_cnt <= gap_cnt - 1'b1;
      end
      if (issue && (nxt.cmd == ACTV))
        page_open <= 1'b1;
      else if (issue && (nxt.cmd == PRCH))
        page_open <= 1'b0;
      if (issue && (nxt.cmd == ARSR))
        ref_ack <= ref_strobe;           // refresh served
    end
  end

  // row and bank of the page opened by ACTV
  always_ff @(posedge CLK)
  begin
    if (issue && (nxt.cmd == ACTV))
    begin
      page_row  <= nxt.addr.row.addr;
      page_bank <= nxt.bank;
    end
  end

endmodule

// ==== src/refresh_timer.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module refresh_timer (
  input  logic CLK,
  input  logic RST,
  output logic ref_strobe
);

  localparam int CNT_W = $clog2(`SD_REF_PERIOD);

  logic [CNT_W-1:0] cnt;

  // scheduler compares the strobe with its own acknowledge copy
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cnt        <= CNT_W'(`SD_REF_PERIOD - 1);
      ref_strobe <= 1'b0;
    end
    else if (cnt == '0)
    begin
      cnt        <= CNT_W'(`SD_REF_PERIOD - 1);   // one toggle per period
      ref_strobe <= ~ref_strobe;
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

// ==== src/sdram_pkg.sv ====
`include "sdram_defines.svh"

package sdram_pkg;

  // encodings as on the SDRAM pins {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } sdram_cmd_e;

  typedef struct packed {
    logic [`SD_PIN_W-`SD_ROW_W-1:0] pad;
    logic [`SD_ROW_W-1:0]           addr;
  } sd_row_view_t;

  typedef struct packed {
    logic [`SD_PIN_W-`SD_COL_W-2:0] pad;
    logic                           ap;     // auto precharge on pin A10
    logic [`SD_COL_W-1:0]           addr;
  } sd_col_view_t;

  // row for ACTV, column for READ/WRTE
  typedef union packed {
    sd_row_view_t row;
    sd_col_view_t col;
  } sdram_addr_u;

  typedef struct packed {
    sdram_cmd_e            cmd;
    logic [`SD_BANK_W-1:0] bank;
    sdram_addr_u           addr;
  } sdram_cmd_t;

  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [`SD_ADDR_W-1:0] addr;
    logic [`SD_DATA_W-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  bulk;   // owner is the bulk port
    logic [`SD_DATA_W-1:0] data;
  } rd_resp_t;

endpackage

// ==== include/sdram_defines.svh ====
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// host address is row, then bank, then column
`define SD_ROW_W       12
`define SD_BANK_W      2
`define SD_COL_W       10
`define SD_ADDR_W      24

`define SD_PIN_W       13        // SDRAM address pins
`define SD_DATA_W      32

// command spacing in clock cycles
`define SD_T_GAP       3         // any command to the next
`define SD_T_WR        5         // write to precharge
`define SD_T_RFC       12        // auto refresh to anything

`define SD_REF_PERIOD  200       // cycles between strobe toggles
`define SD_CAS_LAT     2         // READ to data on dq_in

`endif
